// File: rbfu_top.f
src/rbfu_pkg.sv
src/bfu_pre_stage.sv
src/mod_mul.sv
src/delay_line.sv
src/bfu_post_stage.sv
src/rbfu_top.sv
dv/tb_clock.sv
dv/rbfu_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the rbfu testbench with Verilator and run it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module rbfu_tb -f rbfu_top.f -o rbfu_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build returned $status"
    exit $status
fi

./obj_dir/rbfu_sim
status=$?
if [ $status -ne 0 ]; then
    echo "simulation returned $status"
    exit $status
fi

exit 0

// File: dv/rbfu_trace.txt
// gap mode a0 b0 w0 a1 b1 w1 then expected d0 d1 d2 d3
// every field is hex and gap counts idle cycles before the vector
2 0 1 2 3 64 C8 11 7 CFC AB 1D
0 1 A 14 1 14 A 1 F 5 F CFC
0 0 D00 D00 0 0 D00 1 D00 D00 D00 1
0 1 D00 D00 D00 1 0 D00 D00 0 681 681
0 0 D00 D00 D00 0 1 D00 0 CFF D00 1
1 0 4D2 929 11 BB8 D00 D00 47F 525 BB9 BB7
0 1 4D2 929 11 929 4D2 11 7D 461 7D 8A0
0 0 11 BB8 7D0 D00 CFF CFF 487 89C 3 CFC
3 1 5 CFC 2 BB8 7D0 3E8 0 CF7 9C4 A77
0 0 0 0 D00 680 681 2 0 0 681 67F
0 1 D00 0 5 7 9 D00 680 683 8 D00
0 0 A9E C45 A5D 1 D00 D00 CE8 854 2 0
0 1 A9E C45 A5D C45 A9E A5D 4F1 AD 4F1 C54
5 0 D00 1 D00 0 D00 0 CFF 0 0 0
0 1 0 0 0 CFF D00 1 0 0 67F 681
0 0 1F4 309 6C1 800 400 3 92A 7BF 6FF 901
0 1 1F4 309 6C1 800 400 3 8FF 5A3 600 701
1 0 1 D00 CFF D00 2 681 3 D00 0 CFF
0 1 1 2 D00 3E8 3E7 7D0 682 680 A68 919
0 0 D00 D00 1 1 1 D00 CFF 0 0 2
2 1 0 D00 D00 D00 0 0 680 681 680 0
0 0 2A 7CF BB8 C1C B54 B54 5E9 76C 2CD 86A
0 1 2A 7CF BB8 C1C B54 B54 A7D A5B BB8 B88

// File: dv/rbfu_tb.sv
module rbfu_tb;
    import rbfu_pkg::*;

    localparam string TRACE_PATH     = "dv/rbfu_trace.txt";
    localparam int    RESET_CYCLES   = 16;
    localparam int    PIPE_EDGES     = 5;
    localparam int    TIMEOUT_MARGIN = 20;

    logic     clk;
    logic     arst_n;
    logic     in_valid;
    bfu_req_t in_req;
    logic     out_valid;
    bfu_rsp_t out_rsp;

    int       gaps[$];
    bfu_req_t reqs[$];
    bfu_rsp_t rsps[$];
    bfu_rsp_t exp_q[$];
    int       accept_q[$];
    int       cycle = 0;
    int       limit = 0;
    bit       seen_result = 1'b0;

    tb_clock #(.PERIOD(40)) u_tb_clock (.clk(clk));

    rbfu_top u_rbfu_top (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .in_req    (in_req),
        .out_valid (out_valid),
        .out_rsp   (out_rsp)
    );

    ////////////////////////////////////////////////////////////
    // failure reporting and value checks
    ////////////////////////////////////////////////////////////
    task automatic fail_run(string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(string name, logic [47:0] got, logic [47:0] want);
        if (got !== want) begin
            fail_run($sformatf("Error: %s is 0x%0h, expected 0x%0h", name, got, want));
        end
    endtask

    // trace lines with fewer than twelve fields are comments
    task automatic load_trace();
        int       fd;
        int       n;
        int       gap;
        logic     md;
        coeff_t   a0, b0, w0, a1, b1, w1;
        coeff_t   e0, e1, e2, e3;
        bfu_req_t req;
        string    line;
        fd = $fopen(TRACE_PATH, "r");
        if (fd == 0) begin
            fail_run($sformatf("could not open the trace file %s", TRACE_PATH));
        end else begin
            while (!$feof(fd)) begin
                line = "";
                if ($fgets(line, fd) != 0) begin
                    n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h",
                                gap, md, a0, b0, w0, a1, b1, w1, e0, e1, e2, e3);
                    if (n == 12) begin
                        req.mode  = md ? MODE_INTT : MODE_NTT;
                        req.lane0 = '{a: a0, b: b0, w: w0};
                        req.lane1 = '{a: a1, b: b1, w: w1};
                        gaps.push_back(gap);
                        reqs.push_back(req);
                        rsps.push_back('{d0: e0, d1: e1, d2: e2, d3: e3});
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // a sink captures each result PIPE_EDGES edges after the accept edge
    task automatic take_result();
        bfu_rsp_t want;
        int       acc;
        if (exp_q.size() == 0) begin
            fail_run("out_valid went high with no vector outstanding");
        end else begin
            want        = exp_q.pop_front();
            acc         = accept_q.pop_front();
            seen_result = 1'b1;
            check_value("out_valid latency", 48'(cycle + 1 - acc), 48'(PIPE_EDGES));
            check_value("out_rsp.d0", 48'(out_rsp.d0), 48'(want.d0));
            check_value("out_rsp.d1", 48'(out_rsp.d1), 48'(want.d1));
            check_value("out_rsp.d2", 48'(out_rsp.d2), 48'(want.d2));
            check_value("out_rsp.d3", 48'(out_rsp.d3), 48'(want.d3));
        end
    endtask

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= limit) begin
            fail_run($sformatf("timeout after %0d clock cycles", cycle));
        end
    end

    // outputs sampled half a cycle after the rising edge
    always @(negedge clk) begin
        if (!arst_n) begin
            check_value("out_valid", 48'(out_valid), 48'd0);
            check_value("out_rsp", 48'(out_rsp), 48'd0);
        end else if (out_valid) begin
            take_result();
        end else if (!seen_result) begin
            check_value("out_rsp", 48'(out_rsp), 48'd0);
        end
    end

    ////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////
    initial begin
        arst_n   = 1'b0;
        in_valid = 1'b0;
        in_req   = '0;
        load_trace();
        if (reqs.size() == 0) begin
            fail_run("the trace file holds no vectors");
        end
        limit = RESET_CYCLES + PIPE_EDGES + TIMEOUT_MARGIN + reqs.size();
        foreach (gaps[i]) begin
            limit += gaps[i];
        end

        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        for (int i = 0; i < reqs.size(); i++) begin
            repeat (gaps[i]) begin
                @(negedge clk);
                in_valid = 1'b0;
                in_req   = '0;
            end
            @(negedge clk);
            in_valid = 1'b1;
            in_req   = reqs[i];
            exp_q.push_back(rsps[i]);
            accept_q.push_back(cycle + 1);
        end
        @(negedge clk);
        in_valid = 1'b0;
        in_req   = '0;

        // wait out the pipeline of the last vector
        repeat (PIPE_EDGES + 1) @(negedge clk);

        if (exp_q.size() != 0) begin
            fail_run("expected results were still outstanding at the end");
        end else begin
            $display("Test completed successfully");
            $finish;
        end
    end

endmodule

// File: dv/tb_clock.sv
module tb_clock #(
    parameter int PERIOD = 40
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD / 2) clk = ~clk;
        end
    end

endmodule

// File: src/rbfu_top.sv
module rbfu_top (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               in_valid,
    input  rbfu_pkg::bfu_req_t in_req,
    output logic               out_valid,
    output rbfu_pkg::bfu_rsp_t out_rsp
);
    import rbfu_pkg::*;

    // side band carried around the multipliers
    typedef struct packed {
        coeff_t    o0;
        coeff_t    o1;
        bfu_mode_e mode;
        logic      valid;
    } dly_t;

    lane_op_t  op0;
    lane_op_t  op1;
    coeff_t    w0;
    coeff_t    w1;
    bfu_mode_e pre_mode;
    logic      pre_valid;
    coeff_t    r0;
    coeff_t    r1;
    dly_t      dly_in;
    dly_t      dly_out;

    bfu_pre_stage u_bfu_pre_stage (
        .clk      (clk),
        .arst_n   (arst_n),
        .in_valid (in_valid),
        .in_req   (in_req),
        .op0      (op0),
        .op1      (op1),
        .w0       (w0),
        .w1       (w1),
        .mode     (pre_mode),
        .valid    (pre_valid)
    );

    mod_mul u_mod_mul0 (.clk(clk), .arst_n(arst_n), .a(op0.e), .b(w0), .r(r0));
    mod_mul u_mod_mul1 (.clk(clk), .arst_n(arst_n), .a(op1.e), .b(w1), .r(r1));

    assign dly_in = '{o0: op0.o, o1: op1.o, mode: pre_mode, valid: pre_valid};

    delay_line #(
        .WIDTH ($bits(dly_t)),
        .DEPTH (MUL_LATENCY)
    ) u_delay_line (
        .clk    (clk),
        .arst_n (arst_n),
        .din    (dly_in),
        .dout   (dly_out)
    );

    bfu_post_stage u_bfu_post_stage (
        .clk       (clk),
        .arst_n    (arst_n),
        .o0        (dly_out.o0),
        .o1        (dly_out.o1),
        .r0        (r0),
        .r1        (r1),
        .mode      (dly_out.mode),
        .valid     (dly_out.valid),
        .out_valid (out_valid),
        .out_rsp   (out_rsp)
    );

endmodule

// File: src/bfu_post_stage.sv
module bfu_post_stage (
    input  logic                clk,
    input  logic                arst_n,
    input  rbfu_pkg::coeff_t    o0,
    input  rbfu_pkg::coeff_t    o1,
    input  rbfu_pkg::coeff_t    r0,
    input  rbfu_pkg::coeff_t    r1,
    input  rbfu_pkg::bfu_mode_e mode,
    input  logic                valid,
    output logic                out_valid,
    output rbfu_pkg::bfu_rsp_t  out_rsp
);
    import rbfu_pkg::*;

    coeff_t   o_l  [2];
    coeff_t   r_l  [2];
    coeff_t   hi_l [2];
    coeff_t   lo_l [2];
    bfu_rsp_t rsp_d;

    assign o_l[0] = o0;
    assign o_l[1] = o1;
    assign r_l[0] = r0;
    assign r_l[1] = r1;

    ////////////////////////////////////////////////////////////
    // per lane result select
    ////////////////////////////////////////////////////////////
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            if (mode == MODE_INTT) begin
                // (a+b)/2 and (b-a)w/2
                hi_l[i] = mod_half(o_l[i]);
                lo_l[i] = mod_half(r_l[i]);
            end else begin
                hi_l[i] = mod_add(o_l[i], r_l[i]);
                lo_l[i] = mod_sub(o_l[i], r_l[i]);
            end
        end
    end

    assign rsp_d.d0 = hi_l[0];
    assign rsp_d.d1 = lo_l[0];
    assign rsp_d.d2 = hi_l[1];
    assign rsp_d.d3 = lo_l[1];

    // result register holds the last valid response
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
            out_rsp   <= '0;
        end else begin
            out_valid <= valid;
            if (valid) begin
                out_rsp <= rsp_d;
            end
        end
    end

endmodule

// File: src/delay_line.sv
module delay_line #(
    parameter int unsigned WIDTH = 1,
    parameter int unsigned DEPTH = 1
) (
    input  logic             clk,
    input  logic             arst_n,
    input  logic [WIDTH-1:0] din,
    output logic [WIDTH-1:0] dout
);

    logic [WIDTH-1:0] pipe [DEPTH];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                pipe[i] <= '0;
            end
        end else begin
            pipe[0] <= din;
            for (int i = 1; i < DEPTH; i++) begin
                pipe[i] <= pipe[i-1];
            end
        end
    end

    assign dout = pipe[DEPTH-1];

endmodule

// File: src/mod_mul.sv
module mod_mul (
    input  logic             clk,
    input  logic             arst_n,
    input  rbfu_pkg::coeff_t a,
    input  rbfu_pkg::coeff_t b,
    output rbfu_pkg::coeff_t r
);
    import rbfu_pkg::*;

    // product times factor, 24 + 13 bits
    localparam int unsigned EST_W = 2 * COEFF_W + $clog2(BARRETT_FACTOR + 1);

    prod_t             prod_q;
    prod_t             prod_qq;
    coeff_t            quot_q;
    logic [EST_W-1:0]  est_full;
    prod_t             rem_wide;
    logic [COEFF_W:0]  rem;
    coeff_t            rem_red;

    // quotient estimate never exceeds the true quotient
    assign est_full = EST_W'(prod_q) * EST_W'(BARRETT_FACTOR);

    // remainder is below 2Q, one subtraction finishes it
    assign rem_wide = prod_qq - prod_t'(quot_q) * prod_t'(KYBER_Q);
    assign rem      = rem_wide[COEFF_W:0];

    always_comb begin
        if (rem >= (COEFF_W+1)'(KYBER_Q)) begin
            rem_red = coeff_t'(rem - (COEFF_W+1)'(KYBER_Q));
        end else begin
            rem_red = rem[COEFF_W-1:0];
        end
    end

    ////////////////////////////////////////////////////////////
    // three register stages
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            prod_q  <= '0;
            prod_qq <= '0;
            quot_q  <= '0;
            r       <= '0;
        end else begin
            // stage 1
            prod_q  <= prod_t'(a) * prod_t'(b);
            // stage 2
            prod_qq <= prod_q;
            quot_q  <= est_full[BARRETT_SHIFT +: COEFF_W];
            // stage 3
            r       <= rem_red;
        end
    end

endmodule

// File: src/bfu_pre_stage.sv
module bfu_pre_stage (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                in_valid,
    input  rbfu_pkg::bfu_req_t  in_req,
    output rbfu_pkg::lane_op_t  op0,
    output rbfu_pkg::lane_op_t  op1,
    output rbfu_pkg::coeff_t    w0,
    output rbfu_pkg::coeff_t    w1,
    output rbfu_pkg::bfu_mode_e mode,
    output logic                valid
);
    import rbfu_pkg::*;

    lane_op_t op0_d;
    lane_op_t op1_d;

    // NTT passes a and b straight, INTT forms a+b and b-a
    function automatic lane_op_t form_op(bfu_mode_e m, lane_in_t ln);
        lane_op_t op;
        if (m == MODE_INTT) begin
            op.o = mod_add(ln.a, ln.b);
            op.e = mod_sub(ln.b, ln.a);
        end else begin
            op.o = ln.a;
            op.e = ln.b;
        end
        return op;
    endfunction

    assign op0_d = form_op(in_req.mode, in_req.lane0);
    assign op1_d = form_op(in_req.mode, in_req.lane1);

    ////////////////////////////////////////////////////////////
    // stage register
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid <= 1'b0;
            mode  <= MODE_NTT;
        end else begin
            valid <= in_valid;
            if (in_valid) begin
                mode <= in_req.mode;
            end
        end
    end

    // operands only load on an accepted vector
    always_ff @(posedge clk) begin
        if (in_valid) begin
            op0 <= op0_d;
            op1 <= op1_d;
            w0  <= in_req.lane0.w;
            w1  <= in_req.lane1.w;
        end
    end

endmodule

// File: src/rbfu_pkg.sv
package rbfu_pkg;

    ////////////////////////////////////////////////////////////
    // kyber modulus and Barrett reduction constants
    ////////////////////////////////////////////////////////////
    parameter int unsigned KYBER_Q        = 3329;
    parameter int unsigned COEFF_W        = 12;
    parameter int unsigned BARRETT_FACTOR = 5039;
    parameter int unsigned BARRETT_SHIFT  = 24;
    parameter int unsigned MUL_LATENCY    = 3;

    typedef logic [COEFF_W-1:0]   coeff_t;
    typedef logic [2*COEFF_W-1:0] prod_t;

    typedef enum logic {
        MODE_NTT  = 1'b0,
        MODE_INTT = 1'b1
    } bfu_mode_e;

    typedef struct packed {
        coeff_t a;
        coeff_t b;
        coeff_t w;
    } lane_in_t;

    typedef struct packed {
        bfu_mode_e mode;
        lane_in_t  lane0;
        lane_in_t  lane1;
    } bfu_req_t;

    // o passes around the multiplier, e goes into it
    typedef struct packed {
        coeff_t o;
        coeff_t e;
    } lane_op_t;

    typedef struct packed {
        coeff_t d0;
        coeff_t d1;
        coeff_t d2;
        coeff_t d3;
    } bfu_rsp_t;

    ////////////////////////////////////////////////////////////
    // modular helpers, operands assumed below Q
    ////////////////////////////////////////////////////////////
    function automatic coeff_t mod_add(coeff_t x, coeff_t y);
        logic [COEFF_W:0] s;
        s = {1'b0, x} + {1'b0, y};
        if (s >= (COEFF_W+1)'(KYBER_Q)) begin
            s = s - (COEFF_W+1)'(KYBER_Q);
        end
        return s[COEFF_W-1:0];
    endfunction

    function automatic coeff_t mod_sub(coeff_t x, coeff_t y);
        logic [COEFF_W:0] d;
        d = {1'b0, x} - {1'b0, y};
        // borrow means x < y
        if (d[COEFF_W]) begin
            d = d + (COEFF_W+1)'(KYBER_Q);
        end
        return d[COEFF_W-1:0];
    endfunction

    // x/2 mod Q, odd values get Q added first
    function automatic coeff_t mod_half(coeff_t x);
        logic [COEFF_W:0] t;
        t = {1'b0, x};
        if (x[0]) begin
            t = t + (COEFF_W+1)'(KYBER_Q);
        end
        return t[COEFF_W:1];
    endfunction

endpackage
